// ==== flist.f ====
+incdir+.
gearbox_pkg.sv
tx_seq_gen.sv
tx_gearbox.sv
rx_gearbox.sv
rx_block_sync.sv
gearbox_link.sv
tb_gearbox_link.sv

// ==== gearbox_link.sv ====
`timescale 1ns/1ns
`default_nettype none

module gearbox_link (
    input  wire                         i_clk,
    input  wire                         i_reset,
    input  wire gearbox_pkg::tx_block_t i_tx_block,
    input  wire gearbox_pkg::gb_word_t  i_rx_data,
    output logic                        o_tx_pause,
    output gearbox_pkg::gb_word_t       o_tx_data,
    output gearbox_pkg::rx_block_t      o_rx_block,
    output logic                        o_rx_lock
);

    import gearbox_pkg::*;

    gb_seq_t tx_seq;
    logic    rx_slip;

    // Transmit side, the pause doubles as the source stall
    tx_seq_gen u_tx_seq_gen (
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .o_seq   (tx_seq),
        .o_pause (o_tx_pause)
    );

    tx_gearbox u_tx_gearbox (
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .i_block (i_tx_block),
        .i_seq   (tx_seq),
        .i_pause (o_tx_pause),
        .o_data  (o_tx_data)
    );

    // Receive side runs on its own sequence, steered only by slips
    rx_gearbox u_rx_gearbox (
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .i_data  (i_rx_data),
        .i_slip  (rx_slip),
        .o_block (o_rx_block)
    );

    rx_block_sync u_rx_block_sync (
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .i_block (o_rx_block),
        .o_slip  (rx_slip),
        .o_lock  (o_rx_lock)
    );

endmodule

`default_nettype wire

// ==== gearbox_params.svh ====
`ifndef GEARBOX_PARAMS_SVH
`define GEARBOX_PARAMS_SVH

// Transceiver word width, also the width of one data half of a block
`define GB_DATA_WIDTH 32
`define GB_HEADER_WIDTH 2 // Sync header, 01 or 10 when valid

// The gearbox sequence runs 0..GB_SEQ_MAX, so 33 words carry 16 blocks
`define GB_SEQ_MAX 32
`define GB_SEQ_WIDTH 6

// Consecutive good headers needed before lock is declared
`define GB_LOCK_COUNT 32
// Bad headers within one 64 header window that drop lock
`define GB_BAD_LIMIT 8
// Headers let pass after a slip before judging resumes
`define GB_SLIP_WAIT 4

`endif

// ==== gearbox_pkg.sv ====
`default_nettype none

`include "gearbox_params.svh"

package gearbox_pkg;

    typedef logic [`GB_DATA_WIDTH-1:0] gb_word_t;
    typedef logic [`GB_HEADER_WIDTH-1:0] gb_header_t; // 01 data, 10 control
    typedef logic [`GB_SEQ_WIDTH-1:0] gb_seq_t;

    // One half of a 66-bit block as offered by the transmit source
    typedef struct packed {
        gb_header_t header; // Only looked at when first is set
        gb_word_t   data;
        logic       first;  // Set on the half that follows the sync header
    } tx_block_t;

    // One unpacked half from the receive gearbox
    typedef struct packed {
        gb_header_t header;
        logic       header_valid;
        gb_word_t   data;
        logic       data_valid;
    } rx_block_t;

    typedef enum logic [1:0] {
        HUNT,
        SLIP_WAIT,
        LOCKED
    } sync_state_t;

endpackage

`default_nettype wire

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the gearbox link testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module tb_gearbox_link \
    -f flist.f \
    -o tb_gearbox_link_sim

sim_out=$(./obj_dir/tb_gearbox_link_sim)
echo "$sim_out"

if echo "$sim_out" | grep -qx "TEST PASSED"; then
    exit 0
else
    exit 1
fi

// ==== rx_block_sync.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "gearbox_params.svh"

module rx_block_sync (
    input  wire                         i_clk,
    input  wire                         i_reset,
    input  wire gearbox_pkg::rx_block_t i_block,
    output logic                        o_slip,
    output logic                        o_lock
);

    import gearbox_pkg::*;

    localparam int LOCK_WINDOW = 64; // Headers per bad-count window while locked

    sync_state_t                          state;
    logic                                 hdr_seen;
    logic                                 hdr_good;
    logic [6:0]                           good_cnt; // Also counts the window in LOCKED
    logic [$clog2(`GB_BAD_LIMIT+1)-1:0]   bad_cnt;
    logic [$clog2(`GB_SLIP_WAIT+1)-1:0]   wait_cnt;

    assign hdr_seen = i_block.header_valid;
    assign hdr_good = ^i_block.header; // Only 01 and 10 are legal

    // Slip goes out in the same cycle as the offending header
    assign o_slip = (state == HUNT) && hdr_seen && !hdr_good;
    assign o_lock = (state == LOCKED);

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            state <= HUNT;
            good_cnt <= '0;
            bad_cnt <= '0;
            wait_cnt <= '0;
        end else if (hdr_seen) begin
            case (state)
                HUNT: begin
                    if (!hdr_good) begin
                        state <= SLIP_WAIT;
                        good_cnt <= '0;
                        wait_cnt <= '0;
                    end else if (good_cnt == `GB_LOCK_COUNT - 1) begin
                        state <= LOCKED;
                        good_cnt <= '0;
                        bad_cnt <= '0;
                    end else begin
                        good_cnt <= good_cnt + 1'b1;
                    end
                end
                SLIP_WAIT: begin
                    // Headers still in flight from the old alignment are ignored
                    if (wait_cnt == `GB_SLIP_WAIT - 1) begin
                        state <= HUNT;
                        wait_cnt <= '0;
                    end else begin
                        wait_cnt <= wait_cnt + 1'b1;
                    end
                end
                LOCKED: begin
                    if (!hdr_good && bad_cnt == `GB_BAD_LIMIT - 1) begin
                        state <= HUNT;
                        good_cnt <= '0;
                        bad_cnt <= '0;
                    end else if (good_cnt == LOCK_WINDOW - 1) begin
                        good_cnt <= '0; // New window, bad count starts over
                        bad_cnt <= '0;
                    end else begin
                        good_cnt <= good_cnt + 1'b1;
                        if (!hdr_good) begin
                            bad_cnt <= bad_cnt + 1'b1;
                        end
                    end
                end
                default: state <= HUNT;
            endcase
        end
    end

    // The receive gearbox only offers a header together with the first data half
    a_hdr_with_data: assert property (@(posedge i_clk) disable iff (i_reset)
        i_block.header_valid |-> i_block.data_valid);

endmodule

`default_nettype wire

// ==== rx_gearbox.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "gearbox_params.svh"

module rx_gearbox (
    input  wire                         i_clk,
    input  wire                         i_reset,
    input  wire gearbox_pkg::gb_word_t  i_data,
    input  wire                         i_slip,
    output gearbox_pkg::rx_block_t      o_block
);

    import gearbox_pkg::*;

    localparam int RING_BITS = 2 * `GB_DATA_WIDTH + `GB_HEADER_WIDTH;
    localparam int SEQ_STEPS = `GB_SEQ_MAX + 1;

    gb_seq_t              seq;
    logic                 half_slip;
    logic [6:0]           load_tbl [SEQ_STEPS];
    logic [6:0]           load_pos;
    logic [RING_BITS-1:0] ring;
    logic [RING_BITS-1:0] next_ring;
    logic [RING_BITS:0]   win;
    logic [6:0]           data_base;
    gb_header_t           hdr_sel;
    gb_word_t             data_sel;
    gb_header_t           out_header;
    gb_word_t             out_data;
    logic                 out_hvalid;
    logic                 out_dvalid;

    // Word k of a period starts at ring bit 32*(k+1) mod 66, wrapping past the top
    function automatic logic [6:0] seq_load_pos(input int s);
        if (s == `GB_SEQ_MAX) begin
            return 7'd0;
        end else if (s % 2 == 0) begin
            return 7'(`GB_DATA_WIDTH - s);
        end else begin
            return 7'(RING_BITS - 1 - s);
        end
    endfunction

    for (genvar g = 0; g < SEQ_STEPS; g++) begin : g_load_tbl
        assign load_tbl[g] = seq_load_pos(g);
    end

    assign load_pos = load_tbl[seq];

    // The ring holds one 66-bit block image, each word overwrites its 32 bits in place
    always_comb begin
        int d;
        next_ring = ring;
        for (int i = 0; i < RING_BITS; i++) begin
            d = i - int'(load_pos);
            if (d < 0) begin
                d = d + RING_BITS;
            end
            if (d < `GB_DATA_WIDTH) begin
                next_ring[i] = i_data[d];
            end
        end
    end

    // The extra bit at the bottom repeats ring bit 65 so a half slip can start
    // the block one bit earlier, the header then spans the wrap point
    assign win = {next_ring, next_ring[RING_BITS-1]};

    assign data_base = (seq[0] ? 7'(`GB_HEADER_WIDTH + `GB_DATA_WIDTH) : 7'(`GB_HEADER_WIDTH))
                       + (half_slip ? 7'd0 : 7'd1);
    assign hdr_sel = half_slip ? win[0 +: `GB_HEADER_WIDTH] : win[1 +: `GB_HEADER_WIDTH];
    assign data_sel = win[data_base +: `GB_DATA_WIDTH];

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            seq <= '0;
            half_slip <= 1'b0;
            out_hvalid <= 1'b0;
            out_dvalid <= 1'b0;
        end else begin
            if (i_slip) begin
                half_slip <= !half_slip;
            end

            // Every second slip repeats a sequence value, moving the frame by 32 bits
            if (!(i_slip && half_slip)) begin
                seq <= (seq == `GB_SEQ_MAX) ? '0 : seq + 1'b1;
            end

            out_dvalid <= (seq != `GB_SEQ_MAX); // The last word only tops up the ring
            out_hvalid <= !seq[0] && (seq != `GB_SEQ_MAX);
        end
    end

    always_ff @(posedge i_clk) begin
        ring <= next_ring;
        out_header <= hdr_sel;
        out_data <= data_sel;
    end

    assign o_block = '{
        header:       out_header,
        header_valid: out_hvalid,
        data:         out_data,
        data_valid:   out_dvalid
    };

endmodule

`default_nettype wire

// ==== tb_gearbox_link.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "gearbox_params.svh"

module tb_gearbox_link;

    import gearbox_pkg::*;

    localparam int RESET_CYCLES = 16;
    localparam int PAUSE_CYCLES = 200;
    localparam int CHECK_CYCLES = 400;
    localparam int SLIP_CYCLES = 2 * (`GB_SLIP_WAIT + 8); // Generous time spent per slip
    localparam int LOCK_WAIT = 66 * SLIP_CYCLES + 4 * `GB_LOCK_COUNT;
    localparam int TIMEOUT_CYCLES = 7 * RESET_CYCLES + PAUSE_CYCLES + 5 * CHECK_CYCLES
                                    + 7 * LOCK_WAIT;

    logic      clk;
    logic      hold_reset;
    logic      i_reset;
    tx_block_t i_tx_block;
    gb_word_t  i_rx_data;
    logic      o_tx_pause;
    gb_word_t  o_tx_data;
    rx_block_t o_rx_block;
    logic      o_rx_lock;

    logic [95:0] hist;         // Last three transmit words, newest on top
    int          offset;       // Loopback delay in bits
    logic        next_first;
    gb_header_t  cur_header;
    int          bad_left;     // Blocks still to be sent with an illegal header
    logic        collect;
    logic [31:0] lfsr_state;
    int          cycles;
    int          errors;
    int          tests_run;
    int          tests_failed;
    tx_block_t   sent_q[$];
    rx_block_t   rx_q[$];

    gearbox_link u_gearbox_link (
        .i_clk      (clk),
        .i_reset    (i_reset),
        .i_tx_block (i_tx_block),
        .i_rx_data  (i_rx_data),
        .o_tx_pause (o_tx_pause),
        .o_tx_data  (o_tx_data),
        .o_rx_block (o_rx_block),
        .o_rx_lock  (o_rx_lock)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Galois form, one step per bit handed out
    function automatic logic lfsr_bit();
        logic b;
        b = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (b) begin
            lfsr_state = lfsr_state ^ 32'hA300_0000;
        end
        return b;
    endfunction

    task automatic make_half(output tx_block_t blk);
        gb_word_t d;
        for (int i = 0; i < `GB_DATA_WIDTH; i++) begin
            d[i] = lfsr_bit();
        end
        if (next_first) begin
            if (bad_left > 0) begin
                cur_header = lfsr_bit() ? 2'b11 : 2'b00;
                bad_left = bad_left - 1;
            end else begin
                cur_header = lfsr_bit() ? 2'b10 : 2'b01;
            end
        end
        blk = '{header: next_first ? cur_header : 2'b00, data: d, first: next_first};
        next_first = !next_first;
    endtask

    // Everything the DUT sees changes on the falling edge
    always @(negedge clk) begin : drive_loop
        tx_block_t blk;
        i_reset = hold_reset;
        hist = {o_tx_data, hist[95:32]};
        i_rx_data = hist[64 - offset +: 32]; // Stream is LSB first, older bits sit lower
        if (collect && o_rx_block.data_valid) begin
            rx_q.push_back(o_rx_block);
        end
        if (hold_reset) begin
            i_tx_block = '0;
            next_first = 1'b1;
        end else if (!o_tx_pause) begin
            make_half(blk);
            i_tx_block = blk;
            sent_q.push_back(blk);
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > TIMEOUT_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("TEST FAILED");
            $finish;
        end
    end

    task automatic check_word(input string name, input gb_word_t exp, input gb_word_t got);
        if (exp !== got) begin
            $display("MISMATCH t=%0t %s expected %h got %h", $time, name, exp, got);
            errors = errors + 1;
        end
    endtask

    task automatic check_header(input string name, input gb_header_t exp,
                                input gb_header_t got);
        if (exp !== got) begin
            $display("MISMATCH t=%0t %s expected %b got %b", $time, name, exp, got);
            errors = errors + 1;
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic got);
        if (exp !== got) begin
            $display("MISMATCH t=%0t %s expected %b got %b", $time, name, exp, got);
            errors = errors + 1;
        end
    endtask

    task automatic fail(input string what);
        $display("Error at t=%0t: %s", $time, what);
        errors = errors + 1;
    endtask

    task automatic apply_reset(input int off);
        @(posedge clk);
        hold_reset = 1'b1;
        offset = off;
        collect = 1'b0;
        bad_left = 0;
        sent_q.delete();
        rx_q.delete();
        repeat (RESET_CYCLES) @(posedge clk);
        hold_reset = 1'b0;
        @(posedge clk);
    endtask

    task automatic wait_lock(input logic level, output logic ok);
        int n;
        n = 0;
        ok = 1'b1;
        @(negedge clk);
        while (o_rx_lock !== level) begin
            n = n + 1;
            if (n > LOCK_WAIT) begin
                ok = 1'b0;
                break;
            end
            @(negedge clk);
        end
    endtask

    task automatic finish_test(input string name, input int errors_before);
        tests_run = tests_run + 1;
        if (errors == errors_before) begin
            $display("Test %s passed", name);
        end else begin
            tests_failed = tests_failed + 1;
            $display("Test %s failed with %0d errors", name, errors - errors_before);
        end
    endtask

    // Finds the first received half in the sent stream, then compares in order
    task automatic check_stream();
        int j;
        int k;
        j = -1;
        if (rx_q.size() < CHECK_CYCLES / 2) begin
            fail($sformatf("only %0d halves received after lock", rx_q.size()));
            return;
        end
        for (int i = 0; i < sent_q.size(); i++) begin
            if (j < 0 && sent_q[i].data == rx_q[0].data
                && sent_q[i].first == rx_q[0].header_valid) begin
                j = i;
            end
        end
        if (j < 0) begin
            fail("first received half was never sent");
            return;
        end
        for (k = 0; k < rx_q.size() && j + k < sent_q.size(); k++) begin
            check_word("o_rx_block.data", sent_q[j + k].data, rx_q[k].data);
            check_flag("o_rx_block.header_valid", sent_q[j + k].first, rx_q[k].header_valid);
            if (sent_q[j + k].first) begin
                check_header("o_rx_block.header", sent_q[j + k].header, rx_q[k].header);
            end
        end
    endtask

    task automatic test_reset();
        int e0;
        e0 = errors;
        hold_reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        check_flag("o_tx_pause", 1'b0, o_tx_pause);
        check_flag("o_rx_lock", 1'b0, o_rx_lock);
        check_flag("o_rx_block.header_valid", 1'b0, o_rx_block.header_valid);
        check_flag("o_rx_block.data_valid", 1'b0, o_rx_block.data_valid);
        finish_test("reset state", e0);
    endtask

    task automatic test_pause();
        int e0;
        int last;
        int seen;
        e0 = errors;
        last = -1;
        seen = 0;
        apply_reset(0);
        for (int c = 0; c < PAUSE_CYCLES; c++) begin
            @(negedge clk);
            if (o_tx_pause) begin
                if (last >= 0) begin
                    check_word("o_tx_pause spacing", gb_word_t'(`GB_SEQ_MAX + 1),
                               gb_word_t'(c - last));
                end
                last = c;
                seen = seen + 1;
            end
        end
        if (seen < PAUSE_CYCLES / (`GB_SEQ_MAX + 1)) begin
            fail($sformatf("o_tx_pause was high only %0d times", seen));
        end
        finish_test("pause pattern", e0);
    endtask

    task automatic test_loopback(input int off);
        int e0;
        logic ok;
        e0 = errors;
        apply_reset(off);
        wait_lock(1'b1, ok);
        if (!ok) begin
            fail($sformatf("no lock with offset %0d", off));
        end else begin
            repeat (8) @(posedge clk);
            collect = 1'b1;
            repeat (CHECK_CYCLES) @(posedge clk);
            collect = 1'b0;
            check_flag("o_rx_lock", 1'b1, o_rx_lock);
            check_stream();
        end
        finish_test($sformatf("loopback offset %0d", off), e0);
    endtask

    task automatic test_lock_loss();
        int e0;
        logic ok;
        e0 = errors;
        apply_reset(0);
        wait_lock(1'b1, ok);
        if (!ok) begin
            fail("no lock before the bad header burst");
        end else begin
            // Early in the first window so the whole burst counts against lock
            @(posedge clk);
            bad_left = `GB_BAD_LIMIT;
            wait_lock(1'b0, ok);
            if (!ok) begin
                fail("lock held through the bad header burst");
            end else begin
                wait_lock(1'b1, ok);
                if (!ok) begin
                    fail("lock did not return after valid headers resumed");
                end
            end
        end
        finish_test("loss of lock", e0);
    endtask

    initial begin
        hold_reset = 1'b1;
        i_reset = 1'b1;
        i_tx_block = '0;
        i_rx_data = '0;
        hist = '0;
        offset = 0;
        next_first = 1'b1;
        cur_header = 2'b01;
        bad_left = 0;
        collect = 1'b0;
        lfsr_state = 32'd52;
        cycles = 0;
        errors = 0;
        tests_run = 0;
        tests_failed = 0;

        test_reset();
        test_pause();
        test_loopback(0);
        test_loopback(1);
        test_loopback(17);
        test_loopback(33);
        test_lock_loss();

        $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tx_gearbox.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "gearbox_params.svh"

module tx_gearbox (
    input  wire                         i_clk,
    input  wire                         i_reset,
    input  wire gearbox_pkg::tx_block_t i_block,
    input  wire gearbox_pkg::gb_seq_t   i_seq,
    input  wire                         i_pause,
    output gearbox_pkg::gb_word_t       o_data
);

    localparam int BUF_BITS = 2 * `GB_DATA_WIDTH + `GB_HEADER_WIDTH;

    logic [BUF_BITS-1:0] obuf;
    logic [BUF_BITS-1:0] next_obuf;
    logic                load_header;
    logic [6:0]          hdr_idx;
    logic [6:0]          data_idx;

    // Even sequence values carry header plus first half, odd ones the second half
    assign load_header = !i_seq[0];

    // After the shift the buffer holds seq bits on even values and seq+1 on odd ones,
    // so new bits land right above what is still waiting to go out
    assign hdr_idx = {1'b0, i_seq};
    assign data_idx = load_header ? hdr_idx + 7'd2 : hdr_idx + 7'd1;

    always_comb begin
        next_obuf = obuf >> `GB_DATA_WIDTH; // Low word leaves every cycle
        if (!i_pause) begin
            if (load_header) begin
                next_obuf[hdr_idx +: `GB_HEADER_WIDTH] = i_block.header;
            end
            next_obuf[data_idx +: `GB_DATA_WIDTH] = i_block.data;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            obuf <= '0;
        end else begin
            obuf <= next_obuf;
        end
    end

    // Bits are sent LSB first, header bit 0 leads the block on the line
    assign o_data = obuf[`GB_DATA_WIDTH-1:0];

    // The source must keep its half order in step with the sequence generator
    a_first_parity: assert property (@(posedge i_clk) disable iff (i_reset)
        !i_pause |-> (i_block.first == !i_seq[0]));

endmodule

`default_nettype wire

// ==== tx_seq_gen.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "gearbox_params.svh"

module tx_seq_gen (
    input  wire                     i_clk,
    input  wire                     i_reset,
    output gearbox_pkg::gb_seq_t    o_seq,
    output logic                    o_pause
);

    // Same pacing as the GTY TX gearbox, one stall in every 33 words
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_seq <= '0;
        end else if (o_seq == `GB_SEQ_MAX) begin
            o_seq <= '0;
        end else begin
            o_seq <= o_seq + 1'b1;
        end
    end

    // On the last value the buffer already holds a full word, so the source waits
    assign o_pause = (o_seq == `GB_SEQ_MAX);

    // The source is never held for two words running, so a stall costs exactly one cycle
    a_pause_single: assert property (@(posedge i_clk) disable iff (i_reset)
        o_pause |=> !o_pause);

endmodule

`default_nettype wire
